// ==== verilog.f ====
source/cachePkg.sv
source/memBusPkg.sv
source/tagStore.sv
source/lineStore.sv
source/laneSequencer.sv
source/laneCacheTop.sv
test/globalMemModel.sv
test/laneCacheTb.sv

// ==== run.sh ====
#!/bin/sh
# Build with Verilator, run, and decide on the printed result
cd "$(dirname "$0")" &&
verilator --binary --timing -f verilog.f --top-module laneCacheTb -o laneCacheSim ||
{ echo "Build failed"; exit 1; }
output=$(./obj_dir/laneCacheSim)
echo "$output"
echo "$output" | grep -q "TEST RESULT: PASS" && exit 0 || exit 1

// ==== test/laneCacheTb.sv ====
`timescale 1ns/10ps

module laneCacheTb import cachePkg::*, memBusPkg::*; ();

    localparam int laneCount = 32;
    localparam int maxDelay = 6;
    localparam int testCount = 5;
    localparam int resetCycles = 8;
    localparam int laneWaitLimit = 40 + maxDelay;
    localparam int cycleLimit = testCount * laneCount * (maxDelay + 10) + resetCycles;

    typedef logic [laneCount-1:0] laneMask_t;

    logic clk;
    logic reset;
    laneMask_t readReq;
    laneMask_t writeReq;
    addr_t laneAddr [laneCount];
    word_t writeData [laneCount];
    line_t globalReadData;
    logic globalReadDone;
    logic busy;
    laneMask_t readDone;
    laneMask_t writeDone;
    word_t dataOut [laneCount];
    globalReq_t globalReq;

    int seed;
    int cycleCount = 0;
    word_t expMem [addr_t]; // Expected memory, only words written so far
    word_t expRead [laneCount];
    tag_t cachedTag [lineCount];
    logic cachedValid [lineCount];
    laneMask_t lastWriteMask;

    laneCacheTop i_dut (
        .clk(clk),
        .reset(reset),
        .readReq(readReq),
        .writeReq(writeReq),
        .laneAddr(laneAddr),
        .writeData(writeData),
        .globalReadData(globalReadData),
        .globalReadDone(globalReadDone),
        .busy(busy),
        .readDone(readDone),
        .writeDone(writeDone),
        .dataOut(dataOut),
        .globalReq(globalReq)
    );

    globalMemModel #(
        .maxDelay(maxDelay)
    ) i_mem (
        .clk(clk),
        .reset(reset),
        .globalReq(globalReq),
        .globalReadData(globalReadData),
        .globalReadDone(globalReadDone)
    );

    initial begin
        clk = 1'b1; // First edge is a falling one
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= cycleLimit) begin
            $display("Timeout: the run went past %0d cycles", cycleLimit);
            abortRun();
        end
    end

    task automatic abortRun();
        $display("TEST RESULT: FAIL");
        $fatal(1, "Stopped at the first error");
    endtask

    task automatic checkWord(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("MISMATCH %s: got %h expected %h", name, got, exp);
            abortRun();
        end
    endtask

    task automatic checkMask(input string name, input laneMask_t got, input laneMask_t exp);
        if (got !== exp) begin
            $display("MISMATCH %s: got %h expected %h", name, got, exp);
            abortRun();
        end
    endtask

    task automatic checkCount(input string name, input int got, input int exp);
        if (got != exp) begin
            $display("MISMATCH %s: got %h expected %h", name, got, exp);
            abortRun();
        end
    endtask

    function automatic word_t preloadValue(addr_t a);
        return (a * 32'h9E37_79B1) ^ 32'h5A3C_96E1;
    endfunction

    function automatic word_t expectedWord(addr_t a);
        return expMem.exists(a) ? expMem[a] : preloadValue(a);
    endfunction

    function automatic addr_t makeAddr(tag_t t, index_t idx, wordSel_t w);
        return {7'b0, t, idx, w};
    endfunction

    function automatic word_t randomWord();
        return word_t'($random(seed));
    endfunction

    // Walks the lanes in order with the direct-mapped, no-allocate-on-write rule
    task automatic predictBatch(input laneMask_t rmask, input laneMask_t wmask,
                                output int misses);
        logic [10:0] idx;
        logic [11:0] t;
        misses = 0;
        for (int i = 0; i < laneCount; i++) begin
            idx = laneAddr[i][12:2];
            t = laneAddr[i][24:13];
            if (wmask[i]) begin
                expMem[laneAddr[i]] = writeData[i];
            end else if (rmask[i]) begin
                if (!(cachedValid[idx] && cachedTag[idx] == t)) begin
                    misses++;
                    cachedValid[idx] = 1'b1;
                    cachedTag[idx] = t;
                end
                expRead[i] = expectedWord(laneAddr[i]);
            end
        end
    endtask

    task automatic runBatch(input laneMask_t rmask, input laneMask_t wmask, output int reads);
        laneMask_t readSeen;
        laneMask_t writeSeen;
        int expectedReads;
        int readsBefore;
        int quiet;
        predictBatch(rmask, wmask, expectedReads);
        readSeen = '0;
        writeSeen = '0;
        quiet = 0;
        readsBefore = i_mem.readCount;
        @(negedge clk);
        readReq = rmask;
        writeReq = wmask;
        @(negedge clk);
        readReq = '0;
        writeReq = '0;
        if (!busy) begin
            $display("busy did not rise after a request");
            abortRun();
        end
        while (busy) begin
            readSeen |= readDone;
            writeSeen |= writeDone;
            if ((readDone | writeDone) != '0) begin
                quiet = 0;
            end else begin
                quiet++;
            end
            if (quiet > laneWaitLimit) begin
                $display("A lane did not finish within %0d cycles", laneWaitLimit);
                abortRun();
            end
            @(negedge clk);
        end
        checkMask("readDone", readSeen, rmask & ~wmask);
        checkMask("writeDone", writeSeen, wmask);
        for (int i = 0; i < laneCount; i++) begin
            if (rmask[i] && !wmask[i]) begin
                checkWord($sformatf("dataOut[%0d]", i), dataOut[i], expRead[i]);
            end
        end
        reads = i_mem.readCount - readsBefore;
        checkCount("global reads", reads, expectedReads);
    endtask

    task automatic coldRead();
        int reads;
        int distinct;
        logic seen;
        distinct = 0;
        for (int i = 0; i < laneCount; i++) begin
            laneAddr[i] = makeAddr(12'd0, index_t'($random(seed)), wordSel_t'($random(seed)));
        end
        for (int i = 0; i < laneCount; i++) begin
            seen = 1'b0;
            for (int j = 0; j < i; j++) begin
                seen |= laneAddr[j][31:2] == laneAddr[i][31:2];
            end
            distinct += seen ? 0 : 1;
        end
        runBatch('1, '0, reads);
        checkCount("reads per distinct line", reads, distinct);
    endtask

    task automatic repeatRead();
        int reads;
        runBatch('1, '0, reads);
        checkCount("reads on repeat", reads, 0);
    endtask

    task automatic writeThrough();
        laneMask_t wmask;
        line_t stored;
        int reads;
        wmask = laneMask_t'($random(seed));
        if (wmask == '0) begin
            wmask[0] = 1'b1;
        end
        lastWriteMask = wmask;
        for (int i = 0; i < laneCount; i++) begin
            writeData[i] = randomWord();
        end
        runBatch('0, wmask, reads);
        checkCount("reads during writes", reads, 0);
        for (int i = 0; i < laneCount; i++) begin
            if (wmask[i]) begin
                stored = i_mem.shadow[laneAddr[i][14:2]];
                for (int w = 0; w < wordsPerLine; w++) begin
                    checkWord($sformatf("memory word %0d in line of lane %0d", w, i),
                              stored[w*32 +: 32],
                              expectedWord({laneAddr[i][31:2], wordSel_t'(w)}));
                end
            end
        end
    endtask

    task automatic readAfterWrite();
        int reads;
        runBatch(lastWriteMask, '0, reads);
        checkCount("reads after write hits", reads, 0);
    endtask

    task automatic conflictAndOrder();
        index_t idx;
        laneMask_t mask;
        line_t stored;
        int reads;
        idx = index_t'($random(seed));
        for (int i = 0; i < laneCount; i++) begin
            laneAddr[i] = makeAddr((i % 2 == 1) ? 12'd2 : 12'd1, idx, wordSel_t'($random(seed)));
        end
        runBatch('1, '0, reads);
        checkCount("conflict reads", reads, laneCount); // Alternating tags evict every time
        mask = '0;
        mask[5] = 1'b1;
        mask[20] = 1'b1;
        laneAddr[5] = makeAddr(12'd1, idx, 2'd1);
        laneAddr[20] = laneAddr[5];
        writeData[5] = randomWord();
        writeData[20] = randomWord();
        runBatch('0, mask, reads);
        stored = i_mem.shadow[laneAddr[20][14:2]];
        checkWord("memory word written by two lanes", stored[32 +: 32], writeData[20]);
        laneAddr[0] = laneAddr[20];
        runBatch(laneMask_t'(1), '0, reads);
    endtask

    initial begin
        seed = 33875;
        reset = 1'b1;
        readReq = '0;
        writeReq = '0;
        lastWriteMask = '0;
        for (int i = 0; i < laneCount; i++) begin
            laneAddr[i] = '0;
            writeData[i] = '0;
            expRead[i] = '0;
        end
        for (int i = 0; i < lineCount; i++) begin
            cachedValid[i] = 1'b0;
            cachedTag[i] = '0;
        end
        repeat (resetCycles) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        coldRead();
        repeatRead();
        writeThrough();
        readAfterWrite();
        conflictAndOrder();
        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

// ==== test/globalMemModel.sv ====
`timescale 1ns/10ps

module globalMemModel import cachePkg::*, memBusPkg::*; #(
    parameter int lineAddrBits = 13,
    parameter int maxDelay = 6,
    parameter int seedInit = 33875
) (
    input logic clk,
    input logic reset,
    input globalReq_t globalReq,
    output line_t globalReadData,
    output logic globalReadDone
);

    localparam int lineTotal = 2 ** lineAddrBits;
    localparam int unitBits = lineWidth / byteEnableWidth; // 16-bit units

    line_t shadow [lineTotal];
    int readCount;
    int seed;
    int delayLeft;
    logic pending;
    logic [lineAddrBits-1:0] pendingLine;
    logic [lineAddrBits-1:0] reqLine;

    // Start value of a word, from its full word address
    function automatic word_t initialWord(int lineAddr, int pos);
        logic [31:0] wordAddr;
        wordAddr = 32'(lineAddr) * 4 + 32'(pos);
        return (wordAddr * 32'h9E37_79B1) ^ 32'h5A3C_96E1;
    endfunction

    assign reqLine = globalReq.addr[lineShift +: lineAddrBits];

    // Read data and done move on the falling edge
    always @(negedge clk) begin
        globalReadDone <= 1'b0;
        if (reset) begin
            seed = seedInit;
            pending <= 1'b0;
            delayLeft <= 0;
            readCount <= 0;
            globalReadData <= '0;
            for (int l = 0; l < lineTotal; l++) begin
                for (int w = 0; w < wordsPerLine; w++) begin
                    shadow[l][w*wordWidth +: wordWidth] <= initialWord(l, w);
                end
            end
        end else begin
            if (globalReq.enable && globalReq.write) begin
                for (int u = 0; u < byteEnableWidth; u++) begin
                    if (globalReq.byteEnable[u]) begin
                        shadow[reqLine][u*unitBits +: unitBits] <=
                            globalReq.writeData[u*unitBits +: unitBits];
                    end
                end
            end else if (globalReq.enable) begin
                pending <= 1'b1;
                pendingLine <= reqLine;
                delayLeft <= int'($unsigned($random(seed)) % maxDelay);
                readCount <= readCount + 1;
            end
            if (pending) begin
                if (delayLeft == 0) begin
                    globalReadDone <= 1'b1;
                    globalReadData <= shadow[pendingLine];
                    pending <= 1'b0;
                end else begin
                    delayLeft <= delayLeft - 1;
                end
            end
        end
    end

endmodule

// ==== source/laneCacheTop.sv ====
`timescale 1ns/10ps

module laneCacheTop import cachePkg::*, memBusPkg::*; #(
    parameter int laneCount = 32
) (
    input logic clk,
    input logic reset,
    input logic [laneCount-1:0] readReq,
    input logic [laneCount-1:0] writeReq,
    input addr_t laneAddr [laneCount],
    input word_t writeData [laneCount],
    input line_t globalReadData,
    input logic globalReadDone,
    output logic busy,
    output logic [laneCount-1:0] readDone,
    output logic [laneCount-1:0] writeDone,
    output word_t dataOut [laneCount],
    output globalReq_t globalReq
);

    index_t lookupIndex;
    index_t lineIndex;
    tag_t lookupTag;
    logic tagRead;
    logic tagWrite;
    logic hit;
    logic lineRead;
    logic fill;
    logic [wordsPerLine-1:0] wordWrite;
    line_t lineIn;
    line_t lineOut;

    laneSequencer #(
        .laneCount(laneCount)
    ) i_sequencer (
        .clk(clk),
        .reset(reset),
        .readReq(readReq),
        .writeReq(writeReq),
        .laneAddr(laneAddr),
        .writeData(writeData),
        .hit(hit),
        .lineOut(lineOut),
        .globalReadData(globalReadData),
        .globalReadDone(globalReadDone),
        .busy(busy),
        .readDone(readDone),
        .writeDone(writeDone),
        .dataOut(dataOut),
        .globalReq(globalReq),
        .lookupIndex(lookupIndex),
        .lookupTag(lookupTag),
        .tagRead(tagRead),
        .tagWrite(tagWrite),
        .lineIndex(lineIndex),
        .lineRead(lineRead),
        .wordWrite(wordWrite),
        .fill(fill),
        .lineIn(lineIn)
    );

    tagStore i_tagStore (
        .clk(clk),
        .reset(reset),
        .lookupIndex(lookupIndex),
        .lookupTag(lookupTag),
        .tagRead(tagRead),
        .tagWrite(tagWrite),
        .hit(hit)
    );

    lineStore i_lineStore (
        .clk(clk),
        .lineIndex(lineIndex),
        .lineRead(lineRead),
        .wordWrite(wordWrite),
        .fill(fill),
        .lineIn(lineIn),
        .globalReadData(globalReadData),
        .lineOut(lineOut)
    );

endmodule

// ==== source/laneSequencer.sv ====
`timescale 1ns/10ps

module laneSequencer import cachePkg::*, memBusPkg::*; #(
    parameter int laneCount = 32
) (
    input logic clk,
    input logic reset,
    input logic [laneCount-1:0] readReq,
    input logic [laneCount-1:0] writeReq,
    input addr_t laneAddr [laneCount],
    input word_t writeData [laneCount],
    input logic hit,
    input line_t lineOut,
    input line_t globalReadData,
    input logic globalReadDone,
    output logic busy,
    output logic [laneCount-1:0] readDone,
    output logic [laneCount-1:0] writeDone,
    output word_t dataOut [laneCount],
    output globalReq_t globalReq,
    output index_t lookupIndex,
    output tag_t lookupTag,
    output logic tagRead,
    output logic tagWrite,
    output index_t lineIndex,
    output logic lineRead,
    output logic [wordsPerLine-1:0] wordWrite,
    output logic fill,
    output line_t lineIn
);

    localparam int laneIdxWidth = (laneCount > 1) ? $clog2(laneCount) : 1;
    localparam logic [laneIdxWidth-1:0] lastLane = laneIdxWidth'(laneCount - 1);

    typedef enum logic [3:0] {
        Idle, Load, Lookup, Compare, Deliver, Fetch, Wait, Fill, Update
    } seqState_t;

    seqState_t state;
    seqState_t afterLane;
    logic [laneIdxWidth-1:0] laneIdx;
    logic [laneCount-1:0] readMask;
    logic [laneCount-1:0] writeMask;
    addr_t batchAddr [laneCount];
    word_t batchData [laneCount];
    addr_t curAddr;
    word_t curData;
    logic curWrite;
    wordSel_t curWord;
    logic [wordsPerLine-1:0] wordOneHot;
    logic laneActive;
    logic laneEnd;

    assign curWord = addrWordSel(curAddr);
    assign wordOneHot = {{(wordsPerLine-1){1'b0}}, 1'b1} << curWord;
    assign laneActive = readMask[laneIdx] | writeMask[laneIdx];
    assign afterLane = (laneIdx == lastLane) ? Idle : Load;

    // Last cycle of the current lane
    always_comb begin
        case (state)
            Load: laneEnd = !laneActive;
            Compare: laneEnd = curWrite && !hit; // Write miss, no allocate
            Deliver, Fill, Update: laneEnd = 1'b1;
            default: laneEnd = 1'b0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= Idle;
            laneIdx <= '0;
            readMask <= '0;
            writeMask <= '0;
        end else begin
            case (state)
                Idle: begin
                    if ((|readReq) || (|writeReq)) begin
                        readMask <= readReq & ~writeReq; // Write wins
                        writeMask <= writeReq;
                        laneIdx <= '0;
                        state <= Load;
                    end
                end
                Load: state <= laneActive ? Lookup : afterLane;
                Lookup: state <= Compare;
                Compare: begin
                    if (curWrite) begin
                        state <= hit ? Update : afterLane;
                    end else begin
                        state <= hit ? Deliver : Fetch;
                    end
                end
                Fetch: state <= Wait;
                Wait: state <= globalReadDone ? Fill : Wait;
                Deliver, Fill, Update: state <= afterLane;
                default: state <= Idle;
            endcase
            if (laneEnd) begin
                laneIdx <= laneIdx + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state == Idle) begin
            batchAddr <= laneAddr;
            batchData <= writeData;
        end
        if (state == Load) begin
            curAddr <= batchAddr[laneIdx];
            curData <= batchData[laneIdx];
            curWrite <= writeMask[laneIdx];
        end
        // Lands together with the readDone pulse
        if (state == Compare && !curWrite && hit) begin
            dataOut[laneIdx] <= lineWord(lineOut, curWord);
        end else if (state == Wait && globalReadDone) begin
            dataOut[laneIdx] <= lineWord(globalReadData, curWord);
        end
    end

    assign busy = state != Idle;
    assign lookupIndex = addrIndex(curAddr);
    assign lookupTag = addrTag(curAddr);
    assign lineIndex = addrIndex(curAddr);
    assign tagRead = state == Lookup;
    assign lineRead = state == Lookup;
    assign tagWrite = state == Fill;
    assign fill = (state == Wait) && globalReadDone; // Fetched line only valid here
    assign wordWrite = (state == Update) ? wordOneHot : '0;
    assign lineIn = {wordsPerLine{curData}}; // Byte enables pick the slot

    always_comb begin
        readDone = '0;
        writeDone = '0;
        if (state == Deliver || state == Fill) begin
            readDone[laneIdx] = 1'b1;
        end
        if (state == Compare && curWrite) begin
            writeDone[laneIdx] = 1'b1;
        end

        globalReq.enable = (state == Fetch) || (state == Lookup && curWrite);
        globalReq.write = (state == Lookup) && curWrite;
        globalReq.addr = lineToGlobal(curAddr);
        globalReq.byteEnable = expandByteEnable(wordOneHot);
        globalReq.writeData = lineIn;
    end

endmodule

// ==== source/lineStore.sv ====
`timescale 1ns/10ps

module lineStore import cachePkg::*; (
    input logic clk,
    input index_t lineIndex,
    input logic lineRead,
    input logic [wordsPerLine-1:0] wordWrite,
    input logic fill,
    input line_t lineIn,
    input line_t globalReadData,
    output line_t lineOut
);

    // One word-wide bank per position, a whole line is too wide for one RAM
    word_t bankMem [wordsPerLine][lineCount];
    logic [wordsPerLine-1:0] bankWrite;
    line_t writeLine;

    assign bankWrite = {wordsPerLine{fill}} | wordWrite;
    assign writeLine = fill ? globalReadData : lineIn;

    always_ff @(posedge clk) begin
        for (int b = 0; b < wordsPerLine; b++) begin
            if (bankWrite[b]) begin
                bankMem[b][lineIndex] <= writeLine[b*wordWidth +: wordWidth];
            end
            if (lineRead) begin
                lineOut[b*wordWidth +: wordWidth] <= bankMem[b][lineIndex];
            end
        end
    end

endmodule

// ==== source/tagStore.sv ====
`timescale 1ns/10ps

module tagStore import cachePkg::*; (
    input logic clk,
    input logic reset,
    input index_t lookupIndex,
    input tag_t lookupTag,
    input logic tagRead,
    input logic tagWrite,
    output logic hit
);

    tag_t tagMem [lineCount];
    logic [lineCount-1:0] lineValid;
    tag_t storedTag;
    tag_t compareTag;
    logic storedValid;

    always_ff @(posedge clk) begin
        if (tagWrite) begin
            tagMem[lookupIndex] <= lookupTag;
        end
        if (tagRead) begin
            storedTag <= tagMem[lookupIndex];
            compareTag <= lookupTag; // Held for the compare cycle
        end
    end

    // A cold line never hits
    always_ff @(posedge clk) begin
        if (reset) begin
            lineValid <= '0;
            storedValid <= 1'b0;
        end else begin
            if (tagWrite) begin
                lineValid[lookupIndex] <= 1'b1;
            end
            if (tagRead) begin
                storedValid <= lineValid[lookupIndex];
            end
        end
    end

    assign hit = storedValid && (storedTag == compareTag);

endmodule

// ==== source/memBusPkg.sv ====
package memBusPkg;
    import cachePkg::*;

    localparam int globalAddrWidth = 26;
    localparam int byteEnableWidth = 8;
    localparam int enablesPerWord = byteEnableWidth / wordsPerLine;
    localparam int lineShift = 3; // Global address counts 16-bit units

    typedef logic [globalAddrWidth-1:0] globalAddr_t;
    typedef logic [byteEnableWidth-1:0] byteEnable_t;

    typedef struct packed {
        logic enable;
        logic write;
        globalAddr_t addr;
        byteEnable_t byteEnable;
        line_t writeData;
    } globalReq_t;

    // Line address of a lane word, low bits zero
    function automatic globalAddr_t lineToGlobal(addr_t a);
        return {a[tagLsb+tagWidth-1:indexLsb], {lineShift{1'b0}}};
    endfunction

    function automatic byteEnable_t expandByteEnable(logic [wordsPerLine-1:0] words);
        byteEnable_t be;
        for (int i = 0; i < wordsPerLine; i++) begin
            be[i*enablesPerWord +: enablesPerWord] = {enablesPerWord{words[i]}};
        end
        return be;
    endfunction

endpackage

// ==== source/cachePkg.sv ====
package cachePkg;

    localparam int wordWidth = 32;
    localparam int tagWidth = 12;
    localparam int indexWidth = 11;
    localparam int wordSelWidth = 2;
    localparam int wordsPerLine = 4;
    localparam int lineCount = 2048;
    localparam int lineWidth = wordWidth * wordsPerLine;

    // Lane address fields
    localparam int wordSelLsb = 0;
    localparam int indexLsb = 2;
    localparam int tagLsb = 13;

    typedef logic [wordWidth-1:0] word_t;
    typedef logic [31:0] addr_t; // Word address, not bytes
    typedef logic [tagWidth-1:0] tag_t;
    typedef logic [indexWidth-1:0] index_t;
    typedef logic [wordSelWidth-1:0] wordSel_t;
    typedef logic [lineWidth-1:0] line_t; // Word 0 in the low bits

    function automatic index_t addrIndex(addr_t a);
        return a[indexLsb +: indexWidth];
    endfunction

    function automatic tag_t addrTag(addr_t a);
        return a[tagLsb +: tagWidth];
    endfunction

    function automatic wordSel_t addrWordSel(addr_t a);
        return a[wordSelLsb +: wordSelWidth];
    endfunction

    function automatic word_t lineWord(line_t l, wordSel_t s);
        return l[s * wordWidth +: wordWidth];
    endfunction

endpackage
